// File: verilog/dogPkg.sv
package dogPkg;

    // scene states, in the order the intro plays them
    typedef enum logic [3:0]
    {
        Rest,
        Walk1,
        Walk2,
        Walk3,
        Walk4,
        Sniff1,
        Sniff2,
        Surprised,
        Jump1,
        Jump2,
        Hold
    } sceneState_t;

    // selects which limit the phase counter compares against
    typedef enum logic [2:0]
    {
        phWalkLeg1,
        phSniff,
        phWalkLeg2,
        phSurprised,
        phJump1,
        phJump2
    } phase_t;

    // sprite frame codes seen by the renderer
    localparam logic [4:0] FRAME_REST      = 5'd0;
    localparam logic [4:0] FRAME_WALK1     = 5'd1;
    localparam logic [4:0] FRAME_WALK2     = 5'd2;
    localparam logic [4:0] FRAME_WALK3     = 5'd3;
    localparam logic [4:0] FRAME_WALK4     = 5'd4;
    localparam logic [4:0] FRAME_SNIFF1    = 5'd5;
    localparam logic [4:0] FRAME_SNIFF2    = 5'd6;
    localparam logic [4:0] FRAME_SURPRISED = 5'd7;
    localparam logic [4:0] FRAME_JUMP1     = 5'd8;
    localparam logic [4:0] FRAME_JUMP2     = 5'd9;
    localparam logic [4:0] FRAME_HOLD      = 5'd0;  // blank sprite

    localparam logic [9:0] START_X = 10'd11;   // left edge of the field
    localparam logic [9:0] START_Y = 10'd318;  // ground line

    localparam logic [3:0] JUMP_DX    = 4'd6;  // x advance per jump tick
    localparam int         JUMP_TICKS = 5;     // ticks per jump half

    // rise per tick, read forward going up and backward coming down
    localparam logic [3:0] JUMP_RISE [JUMP_TICKS] = '{4'd12, 4'd9, 4'd6, 4'd3, 4'd1};

endpackage

// File: verilog/dogControl.sv
`timescale 1ns/1ns

module dogControl
(
    input  logic            ANIM_Clk,
    input  logic            rst,
    input  logic            replay,     // one tick pulse, only honoured in Hold
    input  logic            phaseEnd,
    output dogPkg::phase_t  phase,
    output logic            phaseClear,
    output logic            phaseCount,
    output logic            walkStep,
    output logic            jumpStep,
    output logic            jumpUp,
    output logic            jumpClear,
    output logic            posLoad,
    output logic [4:0]      frame,
    output logic            sceneDone
);
    import dogPkg::*;

    sceneState_t state;
    sceneState_t nextState;
    logic        legTwo;      // set once the sniff stop has started
    logic        nextLeg;

    // phase of a state, walk legs split by the leg flag
    function automatic phase_t phaseOf(sceneState_t s, logic leg);
        case (s)
            Walk1, Walk2, Walk3, Walk4: phaseOf = leg ? phWalkLeg2 : phWalkLeg1;
            Sniff1, Sniff2:             phaseOf = phSniff;
            Surprised:                  phaseOf = phSurprised;
            Jump1:                      phaseOf = phJump1;
            Jump2, Hold:                phaseOf = phJump2;  // hold parks on the last limit
            default:                    phaseOf = phWalkLeg1;
        endcase
    endfunction

    function automatic logic [4:0] frameOf(sceneState_t s);
        case (s)
            Walk1:     frameOf = FRAME_WALK1;
            Walk2:     frameOf = FRAME_WALK2;
            Walk3:     frameOf = FRAME_WALK3;
            Walk4:     frameOf = FRAME_WALK4;
            Sniff1:    frameOf = FRAME_SNIFF1;
            Sniff2:    frameOf = FRAME_SNIFF2;
            Surprised: frameOf = FRAME_SURPRISED;
            Jump1:     frameOf = FRAME_JUMP1;
            Jump2:     frameOf = FRAME_JUMP2;
            Hold:      frameOf = FRAME_HOLD;
            default:   frameOf = FRAME_REST;
        endcase
    endfunction

    always_comb
    begin
        nextState = state;
        unique case (state)
            Rest:      nextState = Walk1;
            Walk1:     nextState = Walk2;
            Walk2:     nextState = Walk3;
            Walk3:     nextState = Walk4;
            Walk4:
            begin
                if (!phaseEnd)
                    nextState = Walk1;      // another cycle of this leg
                else if (legTwo)
                    nextState = Surprised;
                else
                    nextState = Sniff1;
            end
            Sniff1:    nextState = Sniff2;
            Sniff2:    nextState = phaseEnd ? Walk1 : Sniff1;
            Surprised: if (phaseEnd) nextState = Jump1;
            Jump1:     if (phaseEnd) nextState = Jump2;
            Jump2:     if (phaseEnd) nextState = Hold;
            Hold:      if (replay) nextState = Rest;   // replay elsewhere is dropped
            default:   nextState = Rest;
        endcase
    end

    // leg flag as it will be after this edge
    assign nextLeg = (nextState == Sniff1) ? 1'b1 :
                     (nextState == Rest)   ? 1'b0 : legTwo;

    assign phase      = phaseOf(state, legTwo);
    assign phaseClear = (phaseOf(nextState, nextLeg) != phase);  // new phase begins
    assign phaseCount = nextState inside {Walk4, Sniff2, Surprised, Jump1, Jump2};

    // motion strobes, taken from the state being entered
    assign walkStep  = nextState inside {Walk1, Walk2, Walk3, Walk4};
    assign jumpStep  = nextState inside {Jump1, Jump2};
    assign jumpUp    = (nextState == Jump1);
    assign jumpClear = (nextState == Surprised);  // index back to the top before takeoff
    assign posLoad   = (nextState == Rest);

    always_ff @(posedge ANIM_Clk)
    begin
        if (rst)
        begin
            state     <= Rest;
            legTwo    <= 1'b0;
            frame     <= FRAME_REST;
            sceneDone <= 1'b0;
        end
        else
        begin
            state     <= nextState;
            legTwo    <= nextLeg;
            frame     <= frameOf(nextState);  // frame lines up with the new state
            sceneDone <= (nextState == Hold);
        end
    end

    frameInRange: assert property (@(posedge ANIM_Clk) disable iff (rst)
        frame <= FRAME_JUMP2)
        else $error("frame code %0d out of range", frame);

    stepsExclusive: assert property (@(posedge ANIM_Clk) disable iff (rst)
        !(walkStep && jumpStep))
        else $error("walk and jump strobes together");

    doneOnlyInHold: assert property (@(posedge ANIM_Clk) disable iff (rst)
        sceneDone |-> state == Hold)
        else $error("sceneDone outside Hold");

endmodule

// File: verilog/phaseCounter.sv
`timescale 1ns/1ns

module phaseCounter
#(
    parameter int unsigned WALK_CYCLES    = 4,
    parameter int unsigned SNIFF_ROUNDS   = 3,
    parameter int unsigned SURPRISE_TICKS = 2
)
(
    input  logic           ANIM_Clk,
    input  logic           rst,
    input  dogPkg::phase_t phase,
    input  logic           phaseClear,
    input  logic           phaseCount,
    output logic           phaseEnd
);
    import dogPkg::*;

    logic [3:0] count;  // units done in the active phase, current tick included
    logic [3:0] limit;

    // walk legs count cycles, sniffing counts rounds, the rest count ticks
    function automatic logic [3:0] limitOf(phase_t p);
        case (p)
            phWalkLeg1, phWalkLeg2: limitOf = 4'(WALK_CYCLES);
            phSniff:                limitOf = 4'(SNIFF_ROUNDS);
            phSurprised:            limitOf = 4'(SURPRISE_TICKS);
            default:                limitOf = 4'(JUMP_TICKS);
        endcase
    endfunction

    assign limit    = limitOf(phase);
    assign phaseEnd = (count == limit);

    always_ff @(posedge ANIM_Clk)
    begin
        if (rst)
            count <= 4'd0;
        else if (phaseClear)
            count <= {3'd0, phaseCount};  // first tick of a phase may already count
        else if (phaseCount)
            count <= count + 4'd1;
    end

    countWithinLimit: assert property (@(posedge ANIM_Clk) disable iff (rst)
        count <= limit)
        else $error("phase count %0d passed limit %0d", count, limit);

endmodule

// File: verilog/jumpArc.sv
`timescale 1ns/1ns

module jumpArc
(
    input  logic       ANIM_Clk,
    input  logic       rst,
    input  logic       jumpClear,
    input  logic       jumpStep,
    input  logic       jumpUp,
    output logic [3:0] jumpDx,
    output logic [3:0] jumpDy
);
    import dogPkg::*;

    localparam logic [2:0] LAST_IDX = 3'(JUMP_TICKS - 1);

    logic [2:0] idx;  // table entry used on the next jump tick

    // offsets only while a jump tick is being taken
    assign jumpDx = jumpStep ? JUMP_DX : 4'd0;
    assign jumpDy = jumpStep ? JUMP_RISE[idx] : 4'd0;  // magnitude, sign picked downstream

    always_ff @(posedge ANIM_Clk)
    begin
        if (rst)
            idx <= 3'd0;
        else if (jumpClear)
            idx <= 3'd0;
        else if (jumpStep)
        begin
            if (jumpUp)
            begin
                if (idx != LAST_IDX)
                    idx <= idx + 3'd1;  // stays on the top entry for the first fall tick
            end
            else if (idx != 3'd0)
                idx <= idx - 3'd1;
        end
    end

endmodule

// File: verilog/dogPosition.sv
`timescale 1ns/1ns

module dogPosition
#(
    parameter int unsigned STEP_SIZE = 4
)
(
    input  logic       ANIM_Clk,
    input  logic       rst,
    input  logic       posLoad,
    input  logic       walkStep,
    input  logic       jumpStep,
    input  logic       jumpUp,
    input  logic [3:0] jumpDx,
    input  logic [3:0] jumpDy,
    output logic [9:0] dogX,
    output logic [9:0] dogY
);
    import dogPkg::*;

    localparam logic [9:0] STEP = 10'(STEP_SIZE);

    logic [9:0] dxWide;
    logic [9:0] dyWide;

    assign dxWide = {6'd0, jumpDx};
    assign dyWide = {6'd0, jumpDy};

    always_ff @(posedge ANIM_Clk)
    begin
        if (rst || posLoad)
        begin
            dogX <= START_X;  // back to the start point
            dogY <= START_Y;
        end
        else if (walkStep)
            dogX <= dogX + STEP;
        else if (jumpStep)
        begin
            dogX <= dogX + dxWide;
            if (jumpUp)
                dogY <= dogY - dyWide;  // screen y grows downward
            else
                dogY <= dogY + dyWide;
        end
    end

    xOnScreen: assert property (@(posedge ANIM_Clk) disable iff (rst)
        dogX < 10'd640)
        else $error("dogX %0d off screen", dogX);

    yOnScreen: assert property (@(posedge ANIM_Clk) disable iff (rst)
        dogY < 10'd480)
        else $error("dogY %0d off screen", dogY);

endmodule

// File: verilog/dogScene.sv
`timescale 1ns/1ns

module dogScene
#(
    parameter int unsigned STEP_SIZE      = 4,
    parameter int unsigned WALK_CYCLES    = 4,
    parameter int unsigned SNIFF_ROUNDS   = 3,
    parameter int unsigned SURPRISE_TICKS = 2
)
(
    input  logic       ANIM_Clk,
    input  logic       rst,
    input  logic       replay,
    output logic [9:0] dogX,
    output logic [9:0] dogY,
    output logic [4:0] frame,
    output logic       sceneDone
);
    import dogPkg::*;

    phase_t     phase;
    logic       phaseClear;
    logic       phaseCount;
    logic       phaseEnd;
    logic       walkStep;
    logic       jumpStep;
    logic       jumpUp;
    logic       jumpClear;
    logic       posLoad;
    logic [3:0] jumpDx;
    logic [3:0] jumpDy;

    dogControl control
    (
        .ANIM_Clk   (ANIM_Clk),
        .rst        (rst),
        .replay     (replay),
        .phaseEnd   (phaseEnd),
        .phase      (phase),
        .phaseClear (phaseClear),
        .phaseCount (phaseCount),
        .walkStep   (walkStep),
        .jumpStep   (jumpStep),
        .jumpUp     (jumpUp),
        .jumpClear  (jumpClear),
        .posLoad    (posLoad),
        .frame      (frame),
        .sceneDone  (sceneDone)
    );

    phaseCounter #(
        .WALK_CYCLES    (WALK_CYCLES),
        .SNIFF_ROUNDS   (SNIFF_ROUNDS),
        .SURPRISE_TICKS (SURPRISE_TICKS)
    ) counter
    (
        .ANIM_Clk   (ANIM_Clk),
        .rst        (rst),
        .phase      (phase),
        .phaseClear (phaseClear),
        .phaseCount (phaseCount),
        .phaseEnd   (phaseEnd)
    );

    jumpArc arc
    (
        .ANIM_Clk  (ANIM_Clk),
        .rst       (rst),
        .jumpClear (jumpClear),
        .jumpStep  (jumpStep),
        .jumpUp    (jumpUp),
        .jumpDx    (jumpDx),
        .jumpDy    (jumpDy)
    );

    dogPosition #(
        .STEP_SIZE (STEP_SIZE)
    ) position
    (
        .ANIM_Clk (ANIM_Clk),
        .rst      (rst),
        .posLoad  (posLoad),
        .walkStep (walkStep),
        .jumpStep (jumpStep),
        .jumpUp   (jumpUp),
        .jumpDx   (jumpDx),
        .jumpDy   (jumpDy),
        .dogX     (dogX),
        .dogY     (dogY)
    );

endmodule

// File: testbench/dogSceneChecker.sv
`timescale 1ns/1ns

module dogSceneChecker
#(
    parameter int unsigned STEP_SIZE      = 4,
    parameter int unsigned WALK_CYCLES    = 4,
    parameter int unsigned SNIFF_ROUNDS   = 3,
    parameter int unsigned SURPRISE_TICKS = 2
)
(
    input  logic        ANIM_Clk,
    input  logic        rst,
    input  logic        replay,
    input  logic [9:0]  dogX,
    input  logic [9:0]  dogY,
    input  logic [4:0]  frame,
    input  logic        sceneDone,
    output int unsigned errorCount,
    output int unsigned checkCount
);
    import dogPkg::*;

    localparam logic [9:0] STEP = 10'(STEP_SIZE);
    // ticks from entering Walk1 up to entering Hold
    localparam int unsigned HOLD_AFTER =
        8 * WALK_CYCLES + 2 * SNIFF_ROUNDS + SURPRISE_TICKS + 2 * JUMP_TICKS;

    sceneState_t mState;
    logic [9:0]  mX;
    logic [9:0]  mY;
    logic        mDone;
    logic        mLeg;                // second walk leg under way
    logic        valid = 1'b0;        // model known once a reset edge was seen
    logic        prevDone = 1'b0;
    int unsigned cycles;              // walk cycles finished in this leg
    int unsigned rounds;              // sniff rounds finished
    int unsigned ticks;               // ticks in surprised, or jump table index
    int unsigned sceneTicks;
    int unsigned errors = 0;
    int unsigned checks = 0;

    assign errorCount = errors;
    assign checkCount = checks;

    // renderer frame table
    function automatic logic [4:0] frameFor(sceneState_t s);
        case (s)
            Walk1:     frameFor = FRAME_WALK1;
            Walk2:     frameFor = FRAME_WALK2;
            Walk3:     frameFor = FRAME_WALK3;
            Walk4:     frameFor = FRAME_WALK4;
            Sniff1:    frameFor = FRAME_SNIFF1;
            Sniff2:    frameFor = FRAME_SNIFF2;
            Surprised: frameFor = FRAME_SURPRISED;
            Jump1:     frameFor = FRAME_JUMP1;
            Jump2:     frameFor = FRAME_JUMP2;
            default:   frameFor = FRAME_REST;   // rest and hold are blank
        endcase
    endfunction

    // one jump tick, rise reads the table forward and the fall reads it backward
    task automatic jumpTick(input logic rising);
        mX = mX + {6'd0, JUMP_DX};
        if (rising)
            mY = mY - {6'd0, JUMP_RISE[ticks]};
        else
            mY = mY + {6'd0, JUMP_RISE[JUMP_TICKS - 1 - ticks]};
        ticks = ticks + 1;
    endtask

    task automatic compareValue(input string what, input logic [9:0] got, input logic [9:0] want);
        checks = checks + 1;
        if (got !== want)
        begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    always @(posedge ANIM_Clk)
    begin
        if (rst)
        begin
            mState     = Rest;
            mX         = START_X;
            mY         = START_Y;
            mDone      = 1'b0;
            mLeg       = 1'b0;
            cycles     = 0;
            rounds     = 0;
            ticks      = 0;
            sceneTicks = 0;
            valid      = 1'b1;
        end
        else if (valid)
        begin
            if (mState != Rest && mState != Hold)
                sceneTicks = sceneTicks + 1;
            case (mState)
                Rest:
                begin
                    mState = Walk1;
                    mX     = mX + STEP;
                end
                Walk1:
                begin
                    mState = Walk2;
                    mX     = mX + STEP;
                end
                Walk2:
                begin
                    mState = Walk3;
                    mX     = mX + STEP;
                end
                Walk3:
                begin
                    mState = Walk4;
                    mX     = mX + STEP;
                end
                Walk4:
                begin
                    cycles = cycles + 1;
                    if (cycles < WALK_CYCLES)
                    begin
                        mState = Walk1;
                        mX     = mX + STEP;
                    end
                    else if (mLeg)
                    begin
                        cycles = 0;
                        mState = Surprised;
                        ticks  = 1;          // first surprised tick
                    end
                    else
                    begin
                        cycles = 0;
                        mState = Sniff1;
                        mLeg   = 1'b1;
                    end
                end
                Sniff1: mState = Sniff2;     // dog stands still
                Sniff2:
                begin
                    rounds = rounds + 1;
                    if (rounds < SNIFF_ROUNDS)
                        mState = Sniff1;
                    else
                    begin
                        rounds = 0;
                        mState = Walk1;      // second leg
                        mX     = mX + STEP;
                    end
                end
                Surprised:
                begin
                    if (ticks < SURPRISE_TICKS)
                        ticks = ticks + 1;
                    else
                    begin
                        mState = Jump1;
                        ticks  = 0;
                        jumpTick(1'b1);
                    end
                end
                Jump1:
                begin
                    if (ticks >= JUMP_TICKS)
                    begin
                        mState = Jump2;
                        ticks  = 0;
                    end
                    jumpTick(mState == Jump1);
                end
                Jump2:
                begin
                    if (ticks < JUMP_TICKS)
                        jumpTick(1'b0);
                    else
                    begin
                        mState = Hold;
                        mDone  = 1'b1;
                    end
                end
                Hold:
                begin
                    if (replay)
                    begin
                        mState     = Rest;
                        mX         = START_X;
                        mY         = START_Y;
                        mDone      = 1'b0;
                        mLeg       = 1'b0;
                        sceneTicks = 0;
                    end
                end
                default: mState = Rest;
            endcase
        end
    end

    // outputs settle after the rising edge, compared half a period later
    always @(negedge ANIM_Clk)
    begin
        if (valid)
        begin
            compareValue("dogX", dogX, mX);
            compareValue("dogY", dogY, mY);
            compareValue("frame", {5'd0, frame}, {5'd0, frameFor(mState)});
            compareValue("sceneDone", {9'd0, sceneDone}, {9'd0, mDone});
            if (sceneDone === 1'b1 && !prevDone)
                compareValue("ticks to Hold", 10'(sceneTicks), 10'(HOLD_AFTER));
            prevDone = (sceneDone === 1'b1);
        end
    end

endmodule

// File: testbench/tb_dogScene.sv
`timescale 1ns/1ns

module tb_dogScene;
    import dogPkg::*;

    localparam int unsigned STEP_SIZE      = 4;
    localparam int unsigned WALK_CYCLES    = 4;
    localparam int unsigned SNIFF_ROUNDS   = 3;
    localparam int unsigned SURPRISE_TICKS = 2;
    localparam int unsigned SCENES         = 6;
    localparam int unsigned RESET_CYCLES   = 16;
    localparam int unsigned SCENE_TICKS    =
        8 * WALK_CYCLES + 2 * SNIFF_ROUNDS + SURPRISE_TICKS + 2 * JUMP_TICKS;  // 50
    // each scene plus its hold wait and room for a mid-scene reset
    localparam int unsigned TIMEOUT = SCENES * (SCENE_TICKS + 16 + 20) + RESET_CYCLES;

    logic        ANIM_Clk = 1'b0;
    logic        rst;
    logic        replay;
    logic [9:0]  dogX;
    logic [9:0]  dogY;
    logic [4:0]  frame;
    logic        sceneDone;
    int unsigned errorCount;
    int unsigned checkCount;
    int unsigned cycleCount = 0;
    int unsigned scenesDone = 0;
    int unsigned resets = 0;

    always #4 ANIM_Clk = ~ANIM_Clk;   // 8 ns animation tick

    dogScene #(
        .STEP_SIZE      (STEP_SIZE),
        .WALK_CYCLES    (WALK_CYCLES),
        .SNIFF_ROUNDS   (SNIFF_ROUNDS),
        .SURPRISE_TICKS (SURPRISE_TICKS)
    ) uut
    (
        .ANIM_Clk  (ANIM_Clk),
        .rst       (rst),
        .replay    (replay),
        .dogX      (dogX),
        .dogY      (dogY),
        .frame     (frame),
        .sceneDone (sceneDone)
    );

    dogSceneChecker #(
        .STEP_SIZE      (STEP_SIZE),
        .WALK_CYCLES    (WALK_CYCLES),
        .SNIFF_ROUNDS   (SNIFF_ROUNDS),
        .SURPRISE_TICKS (SURPRISE_TICKS)
    ) watcher
    (
        .ANIM_Clk   (ANIM_Clk),
        .rst        (rst),
        .replay     (replay),
        .dogX       (dogX),
        .dogY       (dogY),
        .frame      (frame),
        .sceneDone  (sceneDone),
        .errorCount (errorCount),
        .checkCount (checkCount)
    );

    task automatic waitTicks(input int unsigned n);
        repeat (n) @(posedge ANIM_Clk);
    endtask

    task automatic pulseReplay();
        @(posedge ANIM_Clk) replay <= 1'b1;
        @(posedge ANIM_Clk) replay <= 1'b0;   // seen by the DUT on this edge
    endtask

    task automatic midSceneReset(input int unsigned len);
        @(posedge ANIM_Clk) rst <= 1'b1;
        repeat (len) @(posedge ANIM_Clk);
        rst <= 1'b0;
    endtask

    always @(posedge ANIM_Clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT)
        begin
            $display("timeout after %0d cycles, the dog scene never finished", cycleCount);
            $display("TB FAILED");
            $finish;
        end
    end

    initial
    begin
        rst    = 1'b1;
        replay = 1'b0;
        void'($urandom(32'h3c89));
        repeat (RESET_CYCLES) @(posedge ANIM_Clk);
        rst <= 1'b0;
        for (int s = 0; s < SCENES; s++)
        begin
            // about one scene in four is cut short and at least one in the run
            if ($urandom_range(3) == 0 || (s == 3 && resets == 0))
            begin
                waitTicks($urandom_range(12, 2));
                midSceneReset($urandom_range(2, 1));
                resets++;
            end
            waitTicks($urandom_range(30, 1));
            pulseReplay();                        // stray pulse while the dog is still walking
            do
                @(negedge ANIM_Clk);
            while (sceneDone !== 1'b1);
            scenesDone++;
            if (s + 1 < SCENES)
            begin
                waitTicks($urandom_range(15));    // linger in hold
                pulseReplay();
            end
        end
        repeat (2) @(posedge ANIM_Clk);           // last compare has run
        $display("scenes %0d, resets %0d, checks %0d, errors %0d",
                 scenesDone, resets, checkCount, errorCount);
        if (errorCount == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: src.f
verilog/dogPkg.sv
verilog/dogControl.sv
verilog/phaseCounter.sv
verilog/jumpArc.sv
verilog/dogPosition.sv
verilog/dogScene.sv
testbench/dogSceneChecker.sv
testbench/tb_dogScene.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_dogScene -Mdir obj_dir

out=$(./obj_dir/Vtb_dogScene) || true
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
